// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_fetch_subsystem
FLIST     = flist.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^TEST OK$$'

clean:
	rm -rf $(OBJ_DIR)

// ==== boot_rom.sv ====
// Boot ROM line store
`default_nettype none

module boot_rom
(
    input  logic                 clk_i,
    input  logic                 sargantana_rstn,
    input  fetch_pkg::brom_rd_t  rd_i,
    output fetch_pkg::line_rsp_t rsp_o
);

    `include "bootrom_image.svh"

    logic             valid_q;
    fetch_pkg::line_t line_q;

    // Read is registered, line shows up one cycle after en
    always_ff @(posedge clk_i, negedge sargantana_rstn) begin
        if (~sargantana_rstn) begin
            valid_q <= 1'b0;
            line_q  <= '0;
        end else begin
            valid_q <= rd_i.en;
            if (rd_i.en) begin
                line_q <= BROM_IMAGE[rd_i.index];
            end
        end
    end

    assign rsp_o.valid = valid_q;
    assign rsp_o.data  = line_q;

endmodule

`default_nettype wire

// ==== bootrom_image.svh ====
// Boot ROM contents

// Four 32-bit instructions per line, lowest word at the lowest address
localparam fetch_pkg::line_t BROM_IMAGE [fetch_pkg::BROM_LINES] = '{
    128'h0182b283_00028293_00000297_f1402573,  // Hart id, load jump target
    128'h00000013_00000013_00028067_00050463,
    128'h30200073_10500073_00000013_00000013,  // Park loop
    128'h0000006f_0ff0000f_00000013_ffdff06f,
    128'h00100513_00000593_00000613_00000693,
    128'h00000713_00000793_00000813_00000893,
    128'h00000913_00000993_00000a13_00000a93,
    128'h00000b13_00000b93_00000c13_00000c93,
    128'h00000d13_00000d93_00000e13_00000e93,
    128'h00000f13_00000f93_0000100f_00000013,
    128'h30551073_00000297_02028293_00000013,
    128'h34011073_7b241073_7b351073_00000013,
    128'h80000137_00010113_00000013_00000013,
    128'hdeadbeef_cafef00d_0badc0de_12345678,
    128'h00000800_00000000_80000000_00000000,  // Jump table
    128'h5a5a5a5a_a5a5a5a5_0f0f0f0f_f0f0f0f0
};

// ==== fetch_path_router.sv ====
// Uncached fetch router
`default_nettype none

module fetch_path_router
(
    input  logic                  clk_i,
    input  logic                  sargantana_rstn,

    // Core side
    input  fetch_pkg::fetch_req_t fetch_req_i,
    output logic                  fetch_ready_o,
    output fetch_pkg::fetch_rsp_t core_rsp_o,

    // Instruction cache refill stream
    input  fetch_pkg::fetch_rsp_t refill_i,

    // Store side
    output fetch_pkg::brom_rd_t   brom_rd_o,
    input  fetch_pkg::line_rsp_t  brom_rsp_i,
    output fetch_pkg::pbuf_rd_t   pbuf_rd_o,
    input  fetch_pkg::line_rsp_t  pbuf_rsp_i
);

    fetch_pkg::fetch_target_e target;     // Decoded from the current paddr
    fetch_pkg::fetch_target_e target_q;   // Store that owes a line this cycle

    fetch_pkg::paddr_t brom_offset;
    fetch_pkg::paddr_t pbuf_offset;

    fetch_pkg::line_rsp_t uc_rsp;

    // Window check, end address exclusive
    function automatic logic in_window(
        input fetch_pkg::paddr_t addr,
        input fetch_pkg::paddr_t base_addr,
        input fetch_pkg::paddr_t end_addr
    );
        return (addr >= base_addr) && (addr < end_addr);
    endfunction

    // Address decode
    always_comb begin
        if (in_window(fetch_req_i.paddr, fetch_pkg::BROM_BASE, fetch_pkg::BROM_END)) begin
            target = fetch_pkg::TGT_BROM;
        end else if (in_window(fetch_req_i.paddr, fetch_pkg::PROGBUF_BASE,
                               fetch_pkg::PROGBUF_END)) begin
            target = fetch_pkg::TGT_PBUF;
        end else begin
            target = fetch_pkg::TGT_NONE;
        end
    end

    // Ready is a pure address level, valid plays no part
    assign fetch_ready_o = (target != fetch_pkg::TGT_NONE);

    // Window-relative byte offsets
    assign brom_offset = fetch_req_i.paddr - fetch_pkg::BROM_BASE;
    assign pbuf_offset = fetch_req_i.paddr - fetch_pkg::PROGBUF_BASE;

    // Request steering, at most one enable high
    assign brom_rd_o.en    = fetch_req_i.valid && (target == fetch_pkg::TGT_BROM);
    assign brom_rd_o.index = fetch_pkg::brom_idx_t'(brom_offset >> fetch_pkg::LINE_OFFSET);

    assign pbuf_rd_o.en    = fetch_req_i.valid && (target == fetch_pkg::TGT_PBUF);
    assign pbuf_rd_o.index = fetch_pkg::pbuf_idx_t'(pbuf_offset >> fetch_pkg::LINE_OFFSET);

    // Remember which store was issued to
    // Unmapped or idle cycles leave nothing pending
    always_ff @(posedge clk_i, negedge sargantana_rstn) begin
        if (~sargantana_rstn) begin
            target_q <= fetch_pkg::TGT_NONE;
        end else if (fetch_req_i.valid) begin
            target_q <= target;
        end else begin
            target_q <= fetch_pkg::TGT_NONE;
        end
    end

    // Response select, only the issued store is listened to
    always_comb begin
        case (target_q)
            fetch_pkg::TGT_BROM: begin
                uc_rsp = brom_rsp_i;
            end
            fetch_pkg::TGT_PBUF: begin
                uc_rsp = pbuf_rsp_i;
            end
            default: begin
                uc_rsp = '0;
            end
        endcase
    end

    // Merge with the refill stream
    // Uncached line wins, a coinciding refill beat is dropped
    always_comb begin
        if (uc_rsp.valid) begin
            core_rsp_o.valid = 1'b1;
            core_rsp_o.data  = uc_rsp.data;
            core_rsp_o.beat  = '0;           // Single line, always beat 0
        end else begin
            core_rsp_o = refill_i;           // Same-cycle pass-through
        end
    end

endmodule

`default_nettype wire

// ==== fetch_pkg.sv ====
// Uncached fetch path definitions
`default_nettype none

package fetch_pkg;

    // Widths
    localparam int PADDR_WIDTH = 40;
    localparam int LINE_WIDTH  = 128;
    localparam int LINE_OFFSET = 4;    // Byte offset bits within a line
    localparam int BEAT_WIDTH  = 2;

    localparam int BROM_LINES    = 16;
    localparam int PROGBUF_LINES = 4;

    typedef logic [PADDR_WIDTH-1:0]            paddr_t;
    typedef logic [LINE_WIDTH-1:0]             line_t;
    typedef logic [$clog2(BROM_LINES)-1:0]     brom_idx_t;
    typedef logic [$clog2(PROGBUF_LINES)-1:0]  pbuf_idx_t;
    typedef logic [BEAT_WIDTH-1:0]             beat_t;

    // Address map, end addresses are exclusive
    localparam paddr_t BROM_BASE    = 40'h00_0000_0100;
    localparam paddr_t BROM_END     = 40'h00_0000_0200;
    localparam paddr_t PROGBUF_BASE = 40'h00_0000_0800;
    localparam paddr_t PROGBUF_END  = 40'h00_0000_0840;

    // Decoded fetch target
    typedef enum logic [1:0] {
        TGT_NONE = 2'b00,
        TGT_BROM = 2'b01,
        TGT_PBUF = 2'b10
    } fetch_target_e;

    // Uncached fetch request from the core
    typedef struct packed {
        logic   valid;
        paddr_t paddr;
    } fetch_req_t;

    // Line toward the core, also used for the refill stream
    typedef struct packed {
        logic  valid;
        line_t data;
        beat_t beat;
    } fetch_rsp_t;

    // Debug write strobe into the program buffer
    typedef struct packed {
        logic      we;
        pbuf_idx_t index;
        line_t     data;
    } pbuf_wr_t;

    typedef struct packed {
        logic      en;
        brom_idx_t index;
    } brom_rd_t;

    typedef struct packed {
        logic      en;
        pbuf_idx_t index;
    } pbuf_rd_t;

    // Registered line returned by a store
    typedef struct packed {
        logic  valid;
        line_t data;
    } line_rsp_t;

endpackage

`default_nettype wire

// ==== fetch_subsystem.sv ====
// Uncached fetch subsystem top
`default_nettype none

module fetch_subsystem
(
    input  logic                  clk_i,
    input  logic                  sargantana_rstn,

    input  fetch_pkg::fetch_req_t fetch_req_i,    // From the core
    input  fetch_pkg::fetch_rsp_t refill_i,       // From the icache refill
    input  fetch_pkg::pbuf_wr_t   pbuf_wr_i,      // From the debug side

    output logic                  fetch_ready_o,
    output fetch_pkg::fetch_rsp_t core_rsp_o
);

    // Router to store links
    fetch_pkg::brom_rd_t  brom_rd;
    fetch_pkg::pbuf_rd_t  pbuf_rd;
    fetch_pkg::line_rsp_t brom_rsp;
    fetch_pkg::line_rsp_t pbuf_rsp;

    fetch_path_router fetch_path_router_inst (
        .clk_i           (clk_i),
        .sargantana_rstn (sargantana_rstn),
        .fetch_req_i     (fetch_req_i),
        .refill_i        (refill_i),
        .brom_rsp_i      (brom_rsp),
        .pbuf_rsp_i      (pbuf_rsp),
        .fetch_ready_o   (fetch_ready_o),
        .brom_rd_o       (brom_rd),
        .pbuf_rd_o       (pbuf_rd),
        .core_rsp_o      (core_rsp_o)
    );

    boot_rom boot_rom_inst (
        .clk_i           (clk_i),
        .sargantana_rstn (sargantana_rstn),
        .rd_i            (brom_rd),
        .rsp_o           (brom_rsp)
    );

    // Debug writes go straight to the buffer
    program_buffer program_buffer_inst (
        .clk_i           (clk_i),
        .sargantana_rstn (sargantana_rstn),
        .wr_i            (pbuf_wr_i),
        .rd_i            (pbuf_rd),
        .rsp_o           (pbuf_rsp)
    );

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+.
fetch_pkg.sv
boot_rom.sv
program_buffer.sv
fetch_path_router.sv
fetch_subsystem.sv
tb_clock_gen.sv
tb_fetch_checker.sv
tb_fetch_subsystem.sv

// ==== program_buffer.sv ====
// Debug program buffer
`default_nettype none

module program_buffer
(
    input  logic                 clk_i,
    input  logic                 sargantana_rstn,
    input  fetch_pkg::pbuf_wr_t  wr_i,
    input  fetch_pkg::pbuf_rd_t  rd_i,
    output fetch_pkg::line_rsp_t rsp_o
);

    fetch_pkg::line_t mem_q [fetch_pkg::PROGBUF_LINES];

    logic             valid_q;
    fetch_pkg::line_t line_q;

    // Line storage, written only by the debug strobe
    always_ff @(posedge clk_i, negedge sargantana_rstn) begin
        if (~sargantana_rstn) begin
            for (int i = 0; i < fetch_pkg::PROGBUF_LINES; i++) begin
                mem_q[i] <= '0;
            end
        end else if (wr_i.we) begin
            mem_q[wr_i.index] <= wr_i.data;
        end
    end

    // Registered read port
    // A write on the same edge is seen by the next read only
    always_ff @(posedge clk_i, negedge sargantana_rstn) begin
        if (~sargantana_rstn) begin
            valid_q <= 1'b0;
            line_q  <= '0;
        end else begin
            valid_q <= rd_i.en;
            if (rd_i.en) begin
                line_q <= mem_q[rd_i.index];  // Old contents on a collision
            end
        end
    end

    assign rsp_o.valid = valid_q;
    assign rsp_o.data  = line_q;

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
// Testbench clock and reset
`default_nettype none

module tb_clock_gen
(
    output logic clk_o,
    output logic rstn_o
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int HALF_PERIOD  = 5;    // 10 ns clock
    localparam int RESET_CYCLES = 3;

    initial begin
        clk_o = 1'b0;
        forever #HALF_PERIOD clk_o = ~clk_o;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);
        rstn_o = 1'b1;
    end

endmodule

`default_nettype wire

// ==== tb_fetch_checker.sv ====
// Fetch subsystem response checker
`default_nettype none

module tb_fetch_checker
(
    input  logic                  clk_i,
    input  logic                  sargantana_rstn,
    input  fetch_pkg::fetch_req_t fetch_req_i,
    input  fetch_pkg::fetch_rsp_t refill_i,
    input  fetch_pkg::pbuf_wr_t   pbuf_wr_i,
    input  logic                  fetch_ready_i,
    input  fetch_pkg::fetch_rsp_t core_rsp_i,
    output int                    check_count_o,
    output int                    error_count_o
);

    timeunit 1ns;
    timeprecision 100ps;

    `include "bootrom_image.svh"

    fetch_pkg::line_t      pbuf_model [fetch_pkg::PROGBUF_LINES];  // Mirror of debug writes
    logic                  pend_valid;   // A line is owed on core_rsp_o this cycle
    fetch_pkg::line_t      pend_line;
    logic                  exp_ready;
    fetch_pkg::fetch_rsp_t exp_rsp;
    int                    checks = 0;
    int                    errors = 0;

    assign check_count_o = checks;
    assign error_count_o = errors;

    function automatic logic in_rom(input fetch_pkg::paddr_t addr);
        return (addr >= fetch_pkg::BROM_BASE) && (addr < fetch_pkg::BROM_END);
    endfunction

    function automatic logic in_pbuf(input fetch_pkg::paddr_t addr);
        return (addr >= fetch_pkg::PROGBUF_BASE) && (addr < fetch_pkg::PROGBUF_END);
    endfunction

    // Line number inside each window
    function automatic fetch_pkg::brom_idx_t rom_line(input fetch_pkg::paddr_t addr);
        return fetch_pkg::brom_idx_t'((addr - fetch_pkg::BROM_BASE) >> fetch_pkg::LINE_OFFSET);
    endfunction

    function automatic fetch_pkg::pbuf_idx_t pbuf_line(input fetch_pkg::paddr_t addr);
        return fetch_pkg::pbuf_idx_t'((addr - fetch_pkg::PROGBUF_BASE) >> fetch_pkg::LINE_OFFSET);
    endfunction

    task automatic check_value(
        input string            name,
        input fetch_pkg::line_t got,
        input fetch_pkg::line_t exp
    );
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    // Sampled before the DUT flops update on this edge
    always @(posedge clk_i) begin
        if (!sargantana_rstn) begin
            pend_valid = 1'b0;
            pend_line  = '0;
            pbuf_model = '{default: '0};
        end else begin
            exp_ready = in_rom(fetch_req_i.paddr) || in_pbuf(fetch_req_i.paddr);
            check_value("fetch_ready_o", fetch_pkg::line_t'(fetch_ready_i),
                        fetch_pkg::line_t'(exp_ready));

            // Uncached line beats any refill beat
            if (pend_valid) begin
                exp_rsp.valid = 1'b1;
                exp_rsp.data  = pend_line;
                exp_rsp.beat  = '0;
            end else begin
                exp_rsp = refill_i;
            end
            check_value("core_rsp_o.valid", fetch_pkg::line_t'(core_rsp_i.valid),
                        fetch_pkg::line_t'(exp_rsp.valid));
            check_value("core_rsp_o.data", core_rsp_i.data, exp_rsp.data);
            check_value("core_rsp_o.beat", fetch_pkg::line_t'(core_rsp_i.beat),
                        fetch_pkg::line_t'(exp_rsp.beat));

            // Line owed at the next edge
            pend_valid = fetch_req_i.valid && exp_ready;
            if (in_rom(fetch_req_i.paddr)) begin
                pend_line = BROM_IMAGE[rom_line(fetch_req_i.paddr)];
            end else if (in_pbuf(fetch_req_i.paddr)) begin
                pend_line = pbuf_model[pbuf_line(fetch_req_i.paddr)];
            end

            if (pbuf_wr_i.we) begin
                pbuf_model[pbuf_wr_i.index] = pbuf_wr_i.data;  // Seen by later reads only
            end
        end
    end

endmodule

`default_nettype wire

// ==== tb_fetch_subsystem.sv ====
// Fetch subsystem testbench
`default_nettype none

module tb_fetch_subsystem;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int RANDOM_ROWS  = 40;
    localparam int DRAIN_CYCLES = 20;

    // One table row, applied for one cycle
    typedef struct packed {
        fetch_pkg::fetch_req_t req;
        fetch_pkg::fetch_rsp_t refill;
        fetch_pkg::pbuf_wr_t   wr;
    } stim_row_t;

    localparam fetch_pkg::fetch_req_t IDLE_REQ = '0;
    localparam fetch_pkg::fetch_rsp_t NO_BEAT  = '0;
    localparam fetch_pkg::pbuf_wr_t   NO_WRITE = '0;

    localparam fetch_pkg::line_t LINE_A = 128'h0000_0013_0010_0093_0020_0113_0030_0193;
    localparam fetch_pkg::line_t LINE_B = 128'h0010_0073_7b20_0073_1234_abcd_0bad_f00d;
    localparam fetch_pkg::line_t LINE_C = 128'hc0de_0001_c0de_0002_c0de_0003_c0de_0004;
    localparam fetch_pkg::line_t BEAT_X = 128'hfeed_0000_1111_2222_3333_4444_5555_6666;
    localparam fetch_pkg::line_t BEAT_Y = 128'h7777_8888_9999_aaaa_bbbb_cccc_dddd_eeee;

    logic                  clk;
    logic                  sargantana_rstn;
    fetch_pkg::fetch_req_t fetch_req;
    fetch_pkg::fetch_rsp_t refill;
    fetch_pkg::pbuf_wr_t   pbuf_wr;
    logic                  fetch_ready;
    fetch_pkg::fetch_rsp_t core_rsp;
    int                    check_count;
    int                    error_count;

    stim_row_t rows[$];
    int        seed        = 32'hdeae970e;
    int        cycle_count = 0;
    int        cycle_limit = 1000;   // Replaced once the table is built

    tb_clock_gen clock_gen_inst (
        .clk_o  (clk),
        .rstn_o (sargantana_rstn)
    );

    fetch_subsystem fetch_subsystem_inst (
        .clk_i           (clk),
        .sargantana_rstn (sargantana_rstn),
        .fetch_req_i     (fetch_req),
        .refill_i        (refill),
        .pbuf_wr_i       (pbuf_wr),
        .fetch_ready_o   (fetch_ready),
        .core_rsp_o      (core_rsp)
    );

    tb_fetch_checker checker_inst (
        .clk_i           (clk),
        .sargantana_rstn (sargantana_rstn),
        .fetch_req_i     (fetch_req),
        .refill_i        (refill),
        .pbuf_wr_i       (pbuf_wr),
        .fetch_ready_i   (fetch_ready),
        .core_rsp_i      (core_rsp),
        .check_count_o   (check_count),
        .error_count_o   (error_count)
    );

    function automatic fetch_pkg::fetch_req_t request_at(input logic v,
                                                         input fetch_pkg::paddr_t addr);
        fetch_pkg::fetch_req_t r;
        r.valid = v;
        r.paddr = addr;
        return r;
    endfunction

    function automatic fetch_pkg::fetch_rsp_t beat_with(input logic v,
                                                        input fetch_pkg::line_t data,
                                                        input fetch_pkg::beat_t beat);
        fetch_pkg::fetch_rsp_t b;
        b.valid = v;
        b.data  = data;
        b.beat  = beat;
        return b;
    endfunction

    function automatic fetch_pkg::pbuf_wr_t write_line(input logic we,
                                                       input fetch_pkg::pbuf_idx_t idx,
                                                       input fetch_pkg::line_t data);
        fetch_pkg::pbuf_wr_t w;
        w.we    = we;
        w.index = idx;
        w.data  = data;
        return w;
    endfunction

    function automatic fetch_pkg::line_t random_line();
        fetch_pkg::line_t l;
        for (int w = 0; w < 4; w++) begin
            l[w*32 +: 32] = $random(seed);
        end
        return l;
    endfunction

    task automatic add_row(input fetch_pkg::fetch_req_t req, input fetch_pkg::fetch_rsp_t beat,
                           input fetch_pkg::pbuf_wr_t wr);
        stim_row_t r;
        r.req    = req;
        r.refill = beat;
        r.wr     = wr;
        rows.push_back(r);
    endtask

    task automatic build_table();
        logic [7:0]            offset;
        fetch_pkg::paddr_t     addr;
        fetch_pkg::fetch_rsp_t beat;

        // Unmapped, then a mapped address with valid low
        add_row(request_at(1'b1, 40'h0FF), NO_BEAT, NO_WRITE);
        add_row(request_at(1'b1, 40'h200), NO_BEAT, NO_WRITE);
        add_row(request_at(1'b1, 40'h840), NO_BEAT, NO_WRITE);
        add_row(request_at(1'b1, 40'h000), NO_BEAT, NO_WRITE);
        add_row(request_at(1'b1, 40'h10_0000_0100), NO_BEAT, NO_WRITE);
        add_row(request_at(1'b0, 40'h100), NO_BEAT, NO_WRITE);
        // ROM window, both ends and odd offsets
        add_row(request_at(1'b1, 40'h100), NO_BEAT, NO_WRITE);
        add_row(request_at(1'b1, 40'h1F0), NO_BEAT, NO_WRITE);
        add_row(request_at(1'b1, 40'h1FF), NO_BEAT, NO_WRITE);
        add_row(request_at(1'b1, 40'h14C), NO_BEAT, NO_WRITE);
        add_row(request_at(1'b1, 40'h1A8), NO_BEAT, NO_WRITE);
        // Program buffer before any write
        add_row(request_at(1'b1, 40'h800), NO_BEAT, NO_WRITE);
        add_row(request_at(1'b1, 40'h83C), NO_BEAT, NO_WRITE);
        // Debug writes, the third collides with a read of the same line
        add_row(IDLE_REQ, NO_BEAT, write_line(1'b1, 2'd0, LINE_A));
        add_row(IDLE_REQ, NO_BEAT, write_line(1'b1, 2'd2, LINE_B));
        add_row(request_at(1'b1, 40'h810), NO_BEAT, write_line(1'b1, 2'd1, LINE_C));
        add_row(request_at(1'b1, 40'h810), NO_BEAT, NO_WRITE);
        add_row(request_at(1'b1, 40'h800), NO_BEAT, NO_WRITE);
        add_row(request_at(1'b1, 40'h820), NO_BEAT, NO_WRITE);
        add_row(request_at(1'b1, 40'h830), NO_BEAT, NO_WRITE);   // Never written
        add_row(request_at(1'b1, 40'h82F), NO_BEAT, NO_WRITE);
        // Refill beats on an idle uncached path
        add_row(IDLE_REQ, beat_with(1'b1, BEAT_X, 2'd0), NO_WRITE);
        add_row(IDLE_REQ, beat_with(1'b1, BEAT_Y, 2'd1), NO_WRITE);
        add_row(IDLE_REQ, beat_with(1'b1, ~BEAT_X, 2'd2), NO_WRITE);
        add_row(IDLE_REQ, beat_with(1'b1, ~BEAT_Y, 2'd3), NO_WRITE);
        // Refill beat meets an uncached line
        add_row(request_at(1'b1, 40'h130), NO_BEAT, NO_WRITE);
        add_row(IDLE_REQ, beat_with(1'b1, BEAT_X, 2'd3), NO_WRITE);
        add_row(request_at(1'b1, 40'h800), beat_with(1'b1, BEAT_Y, 2'd1), NO_WRITE);
        add_row(IDLE_REQ, beat_with(1'b1, BEAT_X, 2'd2), NO_WRITE);
        // Back to back, alternating stores
        add_row(request_at(1'b1, 40'h100), NO_BEAT, NO_WRITE);
        add_row(request_at(1'b1, 40'h800), NO_BEAT, NO_WRITE);
        add_row(request_at(1'b1, 40'h110), NO_BEAT, NO_WRITE);
        add_row(request_at(1'b1, 40'h820), beat_with(1'b1, BEAT_Y, 2'd2), NO_WRITE);
        add_row(request_at(1'b1, 40'h1E0), NO_BEAT, NO_WRITE);
        add_row(request_at(1'b1, 40'h810), NO_BEAT, NO_WRITE);
        add_row(request_at(1'b1, 40'h150), NO_BEAT, NO_WRITE);
        add_row(request_at(1'b1, 40'h83F), NO_BEAT, NO_WRITE);
        add_row(IDLE_REQ, NO_BEAT, NO_WRITE);

        // Random ROM fetches with random refill traffic alongside
        for (int i = 0; i < RANDOM_ROWS; i++) begin
            offset = 8'($random(seed));
            addr   = fetch_pkg::BROM_BASE + fetch_pkg::paddr_t'(offset);
            beat   = beat_with(1'($random(seed)), random_line(),
                               fetch_pkg::beat_t'($random(seed)));
            add_row(request_at(1'b1, addr), beat, NO_WRITE);
        end
    endtask

    task automatic apply_rows();
        foreach (rows[i]) begin
            @(negedge clk);
            fetch_req = rows[i].req;
            refill    = rows[i].refill;
            pbuf_wr   = rows[i].wr;
        end
        @(negedge clk);
        fetch_req = IDLE_REQ;
        refill    = NO_BEAT;
        pbuf_wr   = NO_WRITE;
    endtask

    initial begin
        fetch_req = IDLE_REQ;
        refill    = NO_BEAT;
        pbuf_wr   = NO_WRITE;
        build_table();
        cycle_limit = rows.size() + DRAIN_CYCLES;
        @(posedge sargantana_rstn);
        apply_rows();
        repeat (2) @(posedge clk);   // Last line still owed
        @(negedge clk);
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Test timed out after %0d cycles, checks: %0d, errors: %0d",
                     cycle_count, check_count, error_count);
            $display("TEST FAILED");
            $finish;
        end
    end

endmodule

`default_nettype wire
